// ==== logic/gpu_core_pkg.sv ====
`default_nettype none

package gpu_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_OP     = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    typedef logic [2:0] alu_ctrl_t;
    localparam alu_ctrl_t ALU_ADD = 3'd0;
    localparam alu_ctrl_t ALU_SUB = 3'd1;
    localparam alu_ctrl_t ALU_AND = 3'd2;
    localparam alu_ctrl_t ALU_OR  = 3'd3;
    localparam alu_ctrl_t ALU_XOR = 3'd4;
    localparam alu_ctrl_t ALU_SLT = 3'd5;

    typedef logic [1:0] imm_src_t;
    localparam imm_src_t IMM_I = 2'd0;
    localparam imm_src_t IMM_S = 2'd1;
    localparam imm_src_t IMM_B = 2'd2;
    localparam imm_src_t IMM_J = 2'd3;

    typedef logic [1:0] src_a_sel_t;
    localparam src_a_sel_t SRC_A_PC     = 2'd0;
    localparam src_a_sel_t SRC_A_OLD_PC = 2'd1;
    localparam src_a_sel_t SRC_A_REG_A  = 2'd2;

    typedef logic [1:0] src_b_sel_t;
    localparam src_b_sel_t SRC_B_REG_B = 2'd0;
    localparam src_b_sel_t SRC_B_IMM   = 2'd1;
    localparam src_b_sel_t SRC_B_FOUR  = 2'd2;

    typedef logic [1:0] result_sel_t;
    localparam result_sel_t RESULT_ALU_OUT    = 2'd0; // Registered ALU output.
    localparam result_sel_t RESULT_DATA       = 2'd1;
    localparam result_sel_t RESULT_ALU_RESULT = 2'd2; // Same-cycle ALU output.

    typedef enum logic [3:0] {
        IDLE, FETCH, DECODE, MEM_ADR, MEM_READ, MEM_WB, MEM_WRITE,
        EXECUTE_R, EXECUTE_I, ALU_WB, JAL, BEQ
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/gpu_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_memory import gpu_core_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic  gpu_clk_i,
    input  word_t address_i,
    input  word_t wr_data_i,
    input  logic  wr_en_i,
    output word_t rd_data_o
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];
    logic [ADDR_BITS-1:0] word_index;

    assign word_index = address_i[ADDR_BITS+1:2]; // Byte address to word index.

    assign rd_data_o = mem[word_index];

    // Synchronous write port.
    always_ff @(posedge gpu_clk_i) begin
        if (wr_en_i) begin
            mem[word_index] <= wr_data_i;
        end
    end

    // Higher address bits would alias onto a lower word.
    a_wr_in_range: assert property (
        @(posedge gpu_clk_i) wr_en_i |-> (address_i[31:2] < MEM_WORDS)
    ) else $error("memory write outside %0d words: %h", MEM_WORDS, address_i);

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import gpu_core_pkg::*; (
    input  logic      gpu_clk_i,
    input  logic      reset_i,
    input  reg_addr_t address_1_i,
    input  reg_addr_t address_2_i,
    input  reg_addr_t address_3_i,
    input  word_t     wr_data_i,
    input  logic      wr_en_i,
    output word_t     rd_data_1_o,
    output word_t     rd_data_2_o
);

    word_t regs [32];

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (address_3_i != '0)) begin
            regs[address_3_i] <= wr_data_i; // Writes to x0 are dropped.
        end
    end

    assign rd_data_1_o = regs[address_1_i];
    assign rd_data_2_o = regs[address_2_i];

    // Reset clears x0 and the write guard keeps it there.
    a_x0_zero: assert property (
        @(posedge gpu_clk_i) disable iff (reset_i) regs[0] == '0
    ) else $error("x0 holds nonzero value %h", regs[0]);

endmodule

`default_nettype wire

// ==== logic/imm_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_extend import gpu_core_pkg::*; (
    input  logic [31:7] instr_i,
    input  imm_src_t    imm_src_i,
    output word_t       imm_ext_o
);

    always_comb begin
        case (imm_src_i)
            IMM_I: imm_ext_o = {{20{instr_i[31]}}, instr_i[31:20]};
            IMM_S: imm_ext_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: begin
                imm_ext_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                             instr_i[11:8], 1'b0};
            end
            IMM_J: begin
                imm_ext_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                             instr_i[30:21], 1'b0};
            end
            default: imm_ext_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import gpu_core_pkg::*; (
    input  word_t     src_a_i,
    input  word_t     src_b_i,
    input  alu_ctrl_t control_i,
    output word_t     result_o,
    output logic      zero_o
);

    logic less_than;

    assign less_than = $signed(src_a_i) < $signed(src_b_i);

    always_comb begin
        case (control_i)
            ALU_ADD: result_o = src_a_i + src_b_i;
            ALU_SUB: result_o = src_a_i - src_b_i; // Also the beq compare.
            ALU_AND: result_o = src_a_i & src_b_i;
            ALU_OR:  result_o = src_a_i | src_b_i;
            ALU_XOR: result_o = src_a_i ^ src_b_i;
            ALU_SLT: result_o = {31'b0, less_than};
            default: result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// ==== logic/core_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_datapath import gpu_core_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic        gpu_clk_i,
    input  logic        reset_i,
    input  logic        pc_write_i,
    input  logic        adr_src_i,
    input  logic        mem_write_i,
    input  logic        ir_write_i,
    input  logic        reg_write_i,
    input  result_sel_t result_src_i,
    input  alu_ctrl_t   alu_control_i,
    input  src_a_sel_t  alu_src_a_i,
    input  src_b_sel_t  alu_src_b_i,
    input  imm_src_t    imm_src_i,
    input  logic        host_sel_i,
    input  logic        host_wr_en_i,
    input  word_t       host_addr_i,
    input  word_t       host_wr_data_i,
    output opcode_t     op_o,
    output logic [2:0]  funct3_o,
    output logic        funct7b5_o,
    output logic        zero_o,
    output word_t       host_rd_data_o
);

    word_t pc, old_pc, instr, data, reg_a, write_data, alu_out;
    word_t mem_addr, mem_wr_data, mem_rd_data;
    word_t rf_rd_data_1, rf_rd_data_2, imm_ext;
    word_t src_a, src_b, alu_result, result;
    logic  mem_wr_en;

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            pc <= '0;
        end else if (pc_write_i) begin
            pc <= result;
        end
    end

    // Host owns the memory port while the core is idle.
    assign mem_addr    = host_sel_i ? host_addr_i : (adr_src_i ? result : pc);
    assign mem_wr_en   = host_sel_i ? host_wr_en_i : mem_write_i;
    assign mem_wr_data = host_sel_i ? host_wr_data_i : write_data;

    gpu_memory #(.MEM_WORDS(MEM_WORDS)) gpu_memory0 (
        .gpu_clk_i (gpu_clk_i),
        .address_i (mem_addr),
        .wr_data_i (mem_wr_data),
        .wr_en_i   (mem_wr_en),
        .rd_data_o (mem_rd_data)
    );

    assign host_rd_data_o = mem_rd_data;

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            instr  <= '0;
            old_pc <= '0;
        end else if (ir_write_i) begin
            instr  <= mem_rd_data;
            old_pc <= pc; // Base for branch and jump targets.
        end
    end

    assign op_o       = instr[6:0];
    assign funct3_o   = instr[14:12];
    assign funct7b5_o = instr[30];

    register_file register_file0 (
        .gpu_clk_i   (gpu_clk_i),
        .reset_i     (reset_i),
        .address_1_i (instr[19:15]),
        .address_2_i (instr[24:20]),
        .address_3_i (instr[11:7]),
        .wr_data_i   (result),
        .wr_en_i     (reg_write_i),
        .rd_data_1_o (rf_rd_data_1),
        .rd_data_2_o (rf_rd_data_2)
    );

    // Stage registers between the multicycle steps.
    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            data       <= '0;
            reg_a      <= '0;
            write_data <= '0;
            alu_out    <= '0;
        end else begin
            data       <= mem_rd_data;
            reg_a      <= rf_rd_data_1;
            write_data <= rf_rd_data_2;
            alu_out    <= alu_result;
        end
    end

    imm_extend imm_extend0 (
        .instr_i   (instr[31:7]),
        .imm_src_i (imm_src_i),
        .imm_ext_o (imm_ext)
    );

    always_comb begin
        case (alu_src_a_i)
            SRC_A_PC:     src_a = pc;
            SRC_A_OLD_PC: src_a = old_pc;
            SRC_A_REG_A:  src_a = reg_a;
            default:      src_a = '0;
        endcase
        case (alu_src_b_i)
            SRC_B_REG_B: src_b = write_data;
            SRC_B_IMM:   src_b = imm_ext;
            SRC_B_FOUR:  src_b = 32'd4;
            default:     src_b = '0;
        endcase
    end

    alu alu0 (
        .src_a_i   (src_a),
        .src_b_i   (src_b),
        .control_i (alu_control_i),
        .result_o  (alu_result),
        .zero_o    (zero_o)
    );

    always_comb begin
        case (result_src_i)
            RESULT_ALU_OUT:    result = alu_out;
            RESULT_DATA:       result = data;
            RESULT_ALU_RESULT: result = alu_result;
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/core_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_controller import gpu_core_pkg::*; (
    input  logic        gpu_clk_i,
    input  logic        reset_i,
    input  logic        start_i,
    input  opcode_t     op_i,
    input  logic [2:0]  funct3_i,
    input  logic        funct7b5_i,
    input  logic        zero_i,
    output logic        pc_write_o,
    output logic        adr_src_o,
    output logic        mem_write_o,
    output logic        ir_write_o,
    output logic        reg_write_o,
    output result_sel_t result_src_o,
    output alu_ctrl_t   alu_control_o,
    output src_a_sel_t  alu_src_a_o,
    output src_b_sel_t  alu_src_b_o,
    output imm_src_t    imm_src_o,
    output logic        host_sel_o,
    output logic        busy_o
);

    ctrl_state_t state, state_next;
    alu_ctrl_t   alu_funct;

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      state_next = start_i ? FETCH : IDLE;
            FETCH:     state_next = DECODE;
            DECODE: begin
                case (op_i)
                    OP_LOAD, OP_STORE: state_next = MEM_ADR;
                    OP_OP:             state_next = EXECUTE_R;
                    OP_IMM:            state_next = EXECUTE_I;
                    OP_JAL:            state_next = JAL;
                    OP_BRANCH:         state_next = (funct3_i == 3'b000) ? BEQ : IDLE;
                    default:           state_next = IDLE; // ebreak and unsupported.
                endcase
            end
            MEM_ADR:   state_next = (op_i == OP_LOAD) ? MEM_READ : MEM_WRITE;
            MEM_READ:  state_next = MEM_WB;
            EXECUTE_R: state_next = ALU_WB;
            EXECUTE_I: state_next = ALU_WB;
            JAL:       state_next = ALU_WB;
            MEM_WB, MEM_WRITE, ALU_WB, BEQ: state_next = FETCH;
            default:   state_next = IDLE;
        endcase
    end

    // funct7b5 picks sub only for register operands.
    always_comb begin
        case (funct3_i)
            3'b000:  alu_funct = (op_i == OP_OP && funct7b5_i) ? ALU_SUB : ALU_ADD;
            3'b010:  alu_funct = ALU_SLT;
            3'b100:  alu_funct = ALU_XOR;
            3'b110:  alu_funct = ALU_OR;
            3'b111:  alu_funct = ALU_AND;
            default: alu_funct = ALU_ADD;
        endcase
    end

    always_comb begin
        pc_write_o    = 1'b0;
        adr_src_o     = 1'b0;
        mem_write_o   = 1'b0;
        ir_write_o    = 1'b0;
        reg_write_o   = 1'b0;
        result_src_o  = RESULT_ALU_OUT;
        alu_control_o = ALU_ADD;
        alu_src_a_o   = SRC_A_PC;
        alu_src_b_o   = SRC_B_FOUR;
        imm_src_o     = IMM_I;
        case (state)
            FETCH: begin
                ir_write_o   = 1'b1;
                pc_write_o   = 1'b1; // PC + 4 straight from the ALU.
                result_src_o = RESULT_ALU_RESULT;
            end
            DECODE: begin
                alu_src_a_o = SRC_A_OLD_PC; // Target lands in alu_out.
                alu_src_b_o = SRC_B_IMM;
                imm_src_o   = (op_i == OP_JAL) ? IMM_J : IMM_B;
            end
            MEM_ADR: begin
                alu_src_a_o = SRC_A_REG_A;
                alu_src_b_o = SRC_B_IMM;
                imm_src_o   = (op_i == OP_STORE) ? IMM_S : IMM_I;
            end
            MEM_READ:  adr_src_o = 1'b1;
            MEM_WRITE: begin
                adr_src_o   = 1'b1;
                mem_write_o = 1'b1;
            end
            MEM_WB: begin
                result_src_o = RESULT_DATA;
                reg_write_o  = 1'b1;
            end
            EXECUTE_R: begin
                alu_src_a_o   = SRC_A_REG_A;
                alu_src_b_o   = SRC_B_REG_B;
                alu_control_o = alu_funct;
            end
            EXECUTE_I: begin
                alu_src_a_o   = SRC_A_REG_A;
                alu_src_b_o   = SRC_B_IMM;
                alu_control_o = alu_funct;
            end
            ALU_WB: reg_write_o = 1'b1;
            JAL: begin
                pc_write_o  = 1'b1;
                alu_src_a_o = SRC_A_OLD_PC; // Link address for ALU_WB.
            end
            BEQ: begin
                alu_src_a_o   = SRC_A_REG_A;
                alu_src_b_o   = SRC_B_REG_B;
                alu_control_o = ALU_SUB;
                pc_write_o    = zero_i;
            end
            default: ;
        endcase
    end

    assign host_sel_o = (state == IDLE);
    assign busy_o     = (state != IDLE);

    a_one_mem_user: assert property (
        @(posedge gpu_clk_i) disable iff (reset_i) !(ir_write_o && mem_write_o)
    ) else $error("instruction fetch and store in the same cycle");

    // Start leaves idle on the next edge.
    a_busy_idle: assert property (
        @(posedge gpu_clk_i) disable iff (reset_i)
        (state == IDLE && start_i) |=> busy_o
    ) else $error("start did not make the core busy");

    // Only DECODE returns the core to idle.
    a_halt_from_decode: assert property (
        @(posedge gpu_clk_i) disable iff (reset_i)
        $fell(busy_o) |-> ($past(state) == DECODE)
    ) else $error("core went idle from a state other than DECODE");

endmodule

`default_nettype wire

// ==== logic/gpu_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_core_top import gpu_core_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic  gpu_clk_i,
    input  logic  reset_i,
    input  logic  start_i,
    input  logic  host_wr_en_i,
    input  word_t host_addr_i,
    input  word_t host_wr_data_i,
    output word_t host_rd_data_o,
    output logic  busy_o
);

    logic        pc_write, adr_src, mem_write, ir_write, reg_write, host_sel;
    logic        funct7b5, zero;
    logic [2:0]  funct3;
    opcode_t     op;
    result_sel_t result_src;
    alu_ctrl_t   alu_control;
    src_a_sel_t  alu_src_a;
    src_b_sel_t  alu_src_b;
    imm_src_t    imm_src;

    core_controller core_controller0 (
        .gpu_clk_i     (gpu_clk_i),
        .reset_i       (reset_i),
        .start_i       (start_i),
        .op_i          (op),
        .funct3_i      (funct3),
        .funct7b5_i    (funct7b5),
        .zero_i        (zero),
        .pc_write_o    (pc_write),
        .adr_src_o     (adr_src),
        .mem_write_o   (mem_write),
        .ir_write_o    (ir_write),
        .reg_write_o   (reg_write),
        .result_src_o  (result_src),
        .alu_control_o (alu_control),
        .alu_src_a_o   (alu_src_a),
        .alu_src_b_o   (alu_src_b),
        .imm_src_o     (imm_src),
        .host_sel_o    (host_sel),
        .busy_o        (busy_o)
    );

    core_datapath #(.MEM_WORDS(MEM_WORDS)) core_datapath0 (
        .gpu_clk_i      (gpu_clk_i),
        .reset_i        (reset_i),
        .pc_write_i     (pc_write),
        .adr_src_i      (adr_src),
        .mem_write_i    (mem_write),
        .ir_write_i     (ir_write),
        .reg_write_i    (reg_write),
        .result_src_i   (result_src),
        .alu_control_i  (alu_control),
        .alu_src_a_i    (alu_src_a),
        .alu_src_b_i    (alu_src_b),
        .imm_src_i      (imm_src),
        .host_sel_i     (host_sel),
        .host_wr_en_i   (host_wr_en_i),
        .host_addr_i    (host_addr_i),
        .host_wr_data_i (host_wr_data_i),
        .op_o           (op),
        .funct3_o       (funct3),
        .funct7b5_o     (funct7b5),
        .zero_o         (zero),
        .host_rd_data_o (host_rd_data_o)
    );

endmodule

`default_nettype wire

// ==== verif/gpu_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_core_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DLY     = 5;
    localparam int RESET_CYCLES  = 8;
    localparam int LOOP_N        = 10;
    localparam int RANDOM_PAIRS  = 20;
    // Executed instructions per test, in run order.
    localparam int TOTAL_INSNS   = 25 + 4 + (4 * LOOP_N + 7) + 4 + RANDOM_PAIRS * 11;
    localparam int MARGIN_CYCLES = 2000; // Host loads, readback and resets.
    localparam int WATCHDOG_CYCLES = TOTAL_INSNS * 5 + MARGIN_CYCLES;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam logic [31:0] POISON      = 32'hDEAD_BEEF;

    logic        gpu_clk_i = 1'b0;
    logic        reset_i;
    logic        start_i;
    logic        host_wr_en_i;
    logic [31:0] host_addr_i;
    logic [31:0] host_wr_data_i;
    logic [31:0] host_rd_data_o;
    logic        busy_o;

    int          errors;
    int          checks;
    integer      seed;
    logic [31:0] prog[$];

    gpu_core_top #(.MEM_WORDS(256)) dut0 (
        .gpu_clk_i      (gpu_clk_i),
        .reset_i        (reset_i),
        .start_i        (start_i),
        .host_wr_en_i   (host_wr_en_i),
        .host_addr_i    (host_addr_i),
        .host_wr_data_i (host_wr_data_i),
        .host_rd_data_o (host_rd_data_o),
        .busy_o         (busy_o)
    );

    always #(CLK_PERIOD / 2) gpu_clk_i = ~gpu_clk_i;

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sw_word(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] beq_word(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic reset_core();
        @(posedge gpu_clk_i);
        #(DRIVE_DLY) reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge gpu_clk_i);
        #(DRIVE_DLY) reset_i = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge gpu_clk_i);
        #(DRIVE_DLY);
        host_addr_i    = addr;
        host_wr_data_i = data;
        host_wr_en_i   = 1'b1;
        @(posedge gpu_clk_i); // Captured on this edge.
        #(DRIVE_DLY) host_wr_en_i = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        @(posedge gpu_clk_i);
        #(DRIVE_DLY) host_addr_i = addr;
        @(negedge gpu_clk_i);
        data = host_rd_data_o;
    endtask

    task automatic check_word(input logic [31:0] addr, input logic [31:0] expected);
        logic [31:0] actual;
        read_word(addr, actual);
        check_value($sformatf("host_rd_data_o[0x%03h]", addr), expected, actual);
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            write_word(32'(i * 4), prog[i]);
        end
    endtask

    task automatic run_to_halt();
        @(posedge gpu_clk_i);
        #(DRIVE_DLY) start_i = 1'b1;
        @(posedge gpu_clk_i);
        #(DRIVE_DLY) start_i = 1'b0;
        if (busy_o !== 1'b1) begin
            errors++;
            $display("core did not go busy after the start pulse at %0t ns", $time);
        end
        while (busy_o === 1'b1) @(negedge gpu_clk_i); // Falls after ebreak.
    endtask

    task automatic host_readback();
        reset_core();
        @(negedge gpu_clk_i);
        check_value("busy_o", 32'd0, {31'd0, busy_o});
        for (int k = 0; k < 8; k++) begin
            write_word(32'h3C0 + 32'(k * 8), {~16'(k * 8 + 32'h3C0), 16'(k * 8 + 32'h3C0)});
        end
        for (int k = 0; k < 8; k++) begin
            check_word(32'h3C0 + 32'(k * 8), {~16'(k * 8 + 32'h3C0), 16'(k * 8 + 32'h3C0)});
        end
        check_value("busy_o", 32'd0, {31'd0, busy_o});
    endtask

    task automatic arithmetic_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected[12];
        a = sext12(12'hFF9); // -7.
        b = sext12(12'h5A3);
        expected[0]  = a;
        expected[1]  = b;
        expected[2]  = a + b;
        expected[3]  = a - b;
        expected[4]  = a & b;
        expected[5]  = a | b;
        expected[6]  = a ^ b;
        expected[7]  = {31'd0, ($signed(a) < $signed(b))};
        expected[8]  = {31'd0, ($signed(b) < $signed(sext12(12'hFFF)))};
        expected[9]  = a & sext12(12'h0F0);
        expected[10] = b | sext12(12'hF00);
        expected[11] = a ^ sext12(12'h7FF);
        reset_core();
        for (int k = 0; k < 12; k++) begin
            write_word(32'h300 + 32'(k * 4), POISON);
        end
        prog.delete();
        prog.push_back(i_type_word(12'hFF9, 5'd0, 3'b000, 5'd1, OPC_IMM));
        prog.push_back(i_type_word(12'h5A3, 5'd0, 3'b000, 5'd2, OPC_IMM));
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(r_type_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4)); // sub
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
        prog.push_back(i_type_word(12'hFFF, 5'd2, 3'b010, 5'd9, OPC_IMM)); // slti against -1.
        prog.push_back(i_type_word(12'h0F0, 5'd1, 3'b111, 5'd10, OPC_IMM));
        prog.push_back(i_type_word(12'hF00, 5'd2, 3'b110, 5'd11, OPC_IMM));
        prog.push_back(i_type_word(12'h7FF, 5'd1, 3'b100, 5'd12, OPC_IMM));
        for (int k = 0; k < 12; k++) begin
            prog.push_back(sw_word(12'(32'h300 + k * 4), 5'(k + 1), 5'd0));
        end
        prog.push_back(EBREAK_WORD);
        load_program();
        run_to_halt();
        for (int k = 0; k < 12; k++) begin
            check_word(32'h300 + 32'(k * 4), expected[k]);
        end
    endtask

    task automatic load_store_program();
        logic [31:0] orig;
        orig = 32'h7FFF_FFF0; // Sum wraps into the sign bit.
        reset_core();
        write_word(32'h280, orig);
        write_word(32'h284, POISON);
        prog.delete();
        prog.push_back(i_type_word(12'h280, 5'd0, 3'b010, 5'd1, OPC_LOAD));
        prog.push_back(i_type_word(12'h020, 5'd1, 3'b000, 5'd2, OPC_IMM));
        prog.push_back(sw_word(12'h284, 5'd2, 5'd0));
        prog.push_back(EBREAK_WORD);
        load_program();
        run_to_halt();
        check_word(32'h284, orig + 32'h20);
        check_word(32'h280, orig);
    endtask

    task automatic branch_loop_program();
        reset_core();
        write_word(32'h2C0, POISON);
        write_word(32'h2C4, POISON);
        prog.delete();
        prog.push_back(i_type_word(12'(LOOP_N), 5'd0, 3'b000, 5'd1, OPC_IMM));
        prog.push_back(i_type_word(12'h000, 5'd0, 3'b000, 5'd2, OPC_IMM));
        prog.push_back(i_type_word(12'h000, 5'd0, 3'b000, 5'd3, OPC_IMM));
        prog.push_back(i_type_word(12'h001, 5'd3, 3'b000, 5'd3, OPC_IMM)); // Loop top at 12.
        prog.push_back(r_type_word(7'h00, 5'd3, 5'd2, 3'b000, 5'd2));
        prog.push_back(beq_word(13'd8, 5'd1, 5'd3)); // Exit to 28.
        prog.push_back(beq_word(13'h1FF4, 5'd0, 5'd0)); // Back by 12.
        prog.push_back(sw_word(12'h2C0, 5'd2, 5'd0));
        prog.push_back(beq_word(13'd8, 5'd0, 5'd2)); // Not taken since the sum is nonzero.
        prog.push_back(i_type_word(12'h05A, 5'd0, 3'b000, 5'd4, OPC_IMM));
        prog.push_back(sw_word(12'h2C4, 5'd4, 5'd0));
        prog.push_back(EBREAK_WORD);
        load_program();
        run_to_halt();
        check_word(32'h2C0, 32'(LOOP_N * (LOOP_N + 1) / 2));
        check_word(32'h2C4, 32'h0000_005A);
    endtask

    task automatic jump_link_program();
        reset_core();
        write_word(32'h2E0, 32'hCAFE_0001);
        write_word(32'h2E4, POISON);
        prog.delete();
        prog.push_back(i_type_word(12'h011, 5'd0, 3'b000, 5'd1, OPC_IMM));
        prog.push_back(jal_word(21'd8, 5'd5)); // At byte 4.
        prog.push_back(sw_word(12'h2E0, 5'd1, 5'd0));
        prog.push_back(sw_word(12'h2E4, 5'd5, 5'd0));
        prog.push_back(EBREAK_WORD);
        load_program();
        run_to_halt();
        check_word(32'h2E0, 32'hCAFE_0001);
        check_word(32'h2E4, 32'd4 + 32'd4);
    endtask

    task automatic random_operands();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected[4];
        reset_core();
        prog.delete();
        prog.push_back(i_type_word(12'h100, 5'd0, 3'b010, 5'd1, OPC_LOAD));
        prog.push_back(i_type_word(12'h104, 5'd0, 3'b010, 5'd2, OPC_LOAD));
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(r_type_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        prog.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd6));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(sw_word(12'(32'h140 + k * 4), 5'(k + 3), 5'd0));
        end
        prog.push_back(EBREAK_WORD);
        load_program();
        for (int p = 0; p < RANDOM_PAIRS; p++) begin
            a = $random(seed);
            b = $random(seed);
            expected[0] = a + b;
            expected[1] = a - b;
            expected[2] = a ^ b;
            expected[3] = {31'd0, ($signed(a) < $signed(b))};
            reset_core();
            write_word(32'h100, a);
            write_word(32'h104, b);
            for (int k = 0; k < 4; k++) begin
                write_word(32'h140 + 32'(k * 4), POISON);
            end
            run_to_halt();
            for (int k = 0; k < 4; k++) begin
                check_word(32'h140 + 32'(k * 4), expected[k]);
            end
        end
    endtask

    initial begin
        reset_i        = 1'b1;
        start_i        = 1'b0;
        host_wr_en_i   = 1'b0;
        host_addr_i    = '0;
        host_wr_data_i = '0;
        errors         = 0;
        checks         = 0;
        seed           = 32'h2ccd98d1;
        host_readback();
        arithmetic_program();
        load_store_program();
        branch_loop_program();
        jump_link_program();
        random_operands();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Bounds the whole run in case busy_o never falls.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the programs did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/gpu_core_pkg.sv
logic/gpu_memory.sv
logic/register_file.sv
logic/imm_extend.sv
logic/alu.sv
logic/core_datapath.sv
logic/core_controller.sv
logic/gpu_core_top.sv
verif/gpu_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = gpu_core_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
